//--- compile.f
design/fabric_pkg.sv
design/config_pkg.sv
design/clb_pins_if.sv
design/config_segment.sv
design/logic_block.sv
design/input_connection_block.sv
design/output_switch_box.sv
design/fabric_tile.sv
testbench/tile_assertions.sv
testbench/tile_tb.sv

//--- design/clb_pins_if.sv
`timescale 1ns/1ns

interface clb_pins_if import fabric_pkg::*; (
   input logic clk,
   input logic reset
);
   lut_in_t lut_in;   // from the connection block
   logic    cin;      // carry into the slice
   logic    cout;     // carry out of the slice
   logic    out;      // block output, comb or registered

   // routing side: feeds the pins, sees the block output
   modport route (
      output lut_in,
      output cin,
      input  out
   );

   // logic block side
   modport lb (
      input  clk,
      input  reset,
      input  lut_in,
      input  cin,
      output out,
      output cout
   );

endinterface

//--- design/config_pkg.sv
package config_pkg;

   import fabric_pkg::*;

   // output switch box source codes
   localparam int         SB_SEL_W = 2;
   localparam logic [1:0] SB_ZERO  = 2'd0;
   localparam logic [1:0] SB_WEST  = 2'd1;   // west block out
   localparam logic [1:0] SB_EAST  = 2'd2;   // east block out
   localparam logic [1:0] SB_CARRY = 2'd3;   // carry out of the tile

   // logic block, 18 bits
   typedef struct packed {
      logic [LUT_SIZE-1:0] truth;        // indexed by the LUT input value
      logic                reg_en;       // take the registered output
      logic                carry_mode;   // xor with cin, drive cout
   } clb_cfg_t;

   // input connection block, 12 bits, pin 3 on top
   typedef struct packed {
      logic [LUT_K-1:0][TRACK_SEL_W-1:0] sel;
   } cb_cfg_t;

   // output switch box, 8 bits, track 3 on top
   typedef struct packed {
      logic [N_OUT_TRACKS-1:0][SB_SEL_W-1:0] sel;
   } sb_cfg_t;

   // chain order from cfg_bit: cb_w, clb_w, cb_e, clb_e, sb
   localparam int CFG_BITS = 2 * $bits(cb_cfg_t)
                           + 2 * $bits(clb_cfg_t)
                           + $bits(sb_cfg_t);

endpackage

//--- design/config_segment.sv
`timescale 1ns/1ns

module config_segment #(
   parameter type cfg_t = logic [7:0]
) (
   input  logic clk,
   input  logic reset,
   input  logic shift,
   input  logic data_in,
   output logic data_out,
   output cfg_t cfg
);
   logic [$bits(cfg_t)-1:0] sr;   // one block's bits

   // moves toward the MSB, new bit at the LSB
   always_ff @(posedge clk) begin
      if (reset) begin
         sr <= '0;
      end else if (shift) begin
         sr <= {sr[$bits(cfg_t)-2:0], data_in};
      end
   end

   // next segment reads the top bit
   assign data_out = sr[$bits(cfg_t)-1];

   // live config, valid only after a full load
   assign cfg = cfg_t'(sr);

endmodule

//--- design/fabric_pkg.sv
package fabric_pkg;

   // tile geometry
   localparam int N_IN_TRACKS  = 8;   // single-length input tracks
   localparam int N_OUT_TRACKS = 4;   // single-length output tracks

   // logic block size
   localparam int LUT_K    = 4;
   localparam int LUT_SIZE = 1 << LUT_K;   // truth table bits

   // index of one input track, 3 bits for 8 tracks
   localparam int TRACK_SEL_W = $clog2(N_IN_TRACKS);

   // track bundles as seen at the tile boundary
   typedef logic [N_IN_TRACKS-1:0]  in_tracks_t;
   typedef logic [N_OUT_TRACKS-1:0] out_tracks_t;

   // pins of one LUT, bit 0 is pin 0
   typedef logic [LUT_K-1:0] lut_in_t;

endpackage

//--- design/fabric_tile.sv
`timescale 1ns/1ns

module fabric_tile import fabric_pkg::*, config_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        cfg_shift,
   input  logic        cfg_bit,
   input  logic        carry_in,
   input  in_tracks_t  in_tracks,
   output logic        cfg_out,
   output logic        carry_out,
   output out_tracks_t out_tracks
);
   cb_cfg_t  cfg_cb_w;
   cb_cfg_t  cfg_cb_e;
   clb_cfg_t cfg_clb_w;
   clb_cfg_t cfg_clb_e;
   sb_cfg_t  cfg_sb;

   // chain links, named after the segment they leave
   logic chain_cb_w;
   logic chain_clb_w;
   logic chain_cb_e;
   logic chain_clb_e;

   clb_pins_if pins_w (.clk(clk), .reset(reset));
   clb_pins_if pins_e (.clk(clk), .reset(reset));

   config_segment #(.cfg_t(cb_cfg_t)) seg_cb_w (
      .clk(clk), .reset(reset), .shift(cfg_shift),
      .data_in(cfg_bit), .data_out(chain_cb_w), .cfg(cfg_cb_w)
   );
   config_segment #(.cfg_t(clb_cfg_t)) seg_clb_w (
      .clk(clk), .reset(reset), .shift(cfg_shift),
      .data_in(chain_cb_w), .data_out(chain_clb_w), .cfg(cfg_clb_w)
   );
   config_segment #(.cfg_t(cb_cfg_t)) seg_cb_e (
      .clk(clk), .reset(reset), .shift(cfg_shift),
      .data_in(chain_clb_w), .data_out(chain_cb_e), .cfg(cfg_cb_e)
   );
   config_segment #(.cfg_t(clb_cfg_t)) seg_clb_e (
      .clk(clk), .reset(reset), .shift(cfg_shift),
      .data_in(chain_cb_e), .data_out(chain_clb_e), .cfg(cfg_clb_e)
   );
   config_segment #(.cfg_t(sb_cfg_t)) seg_sb (
      .clk(clk), .reset(reset), .shift(cfg_shift),
      .data_in(chain_clb_e), .data_out(cfg_out), .cfg(cfg_sb)
   );

   input_connection_block cb_w (.in_tracks(in_tracks), .pins(pins_w), .cfg(cfg_cb_w));
   input_connection_block cb_e (.in_tracks(in_tracks), .pins(pins_e), .cfg(cfg_cb_e));

   logic_block clb_w (.pins(pins_w), .cfg(cfg_clb_w));
   logic_block clb_e (.pins(pins_e), .cfg(cfg_clb_e));

   // one-way carry, west to east
   assign pins_w.cin = carry_in;
   assign pins_e.cin = pins_w.cout;
   assign carry_out  = pins_e.cout;

   output_switch_box sb (
      .west(pins_w.out),
      .east(pins_e.out),
      .carry(pins_e.cout),   // lets the adder show its top bit
      .out_tracks(out_tracks),
      .cfg(cfg_sb)
   );

endmodule

//--- design/input_connection_block.sv
`timescale 1ns/1ns

module input_connection_block import fabric_pkg::*, config_pkg::*; (
   input in_tracks_t  in_tracks,
   clb_pins_if.route  pins,
   input cb_cfg_t     cfg
);
   lut_in_t pin_val;

   // any track onto any pin
   always_comb begin
      for (int p = 0; p < LUT_K; p++) begin
         pin_val[p] = in_tracks[cfg.sel[p]];   // 8:1 per pin
      end
   end

   assign pins.lut_in = pin_val;

endmodule

//--- design/logic_block.sv
`timescale 1ns/1ns

module logic_block import fabric_pkg::*, config_pkg::*; (
   clb_pins_if.lb  pins,
   input clb_cfg_t cfg
);
   lut_in_t idx;
   logic    a;        // adder operand bit, pin 0
   logic    b;        // adder operand bit, pin 1
   logic    lut;
   logic    result;
   logic    carry;
   logic    q;        // output flop

   assign idx = pins.lut_in;
   assign a   = idx[0];
   assign b   = idx[1];

   // 16:1 truth table read
   assign lut = cfg.truth[idx];

   // carry slice
   always_comb begin
      if (cfg.carry_mode) begin
         result = lut ^ pins.cin;   // sum when lut = a ^ b
         carry  = (a & b) | (a & pins.cin) | (b & pins.cin);
      end else begin
         result = lut;
         carry  = 1'b0;
      end
   end

   always_ff @(posedge pins.clk) begin
      if (pins.reset) begin
         q <= 1'b0;
      end else begin
         q <= result;
      end
   end

   // carry path never goes through the flop
   assign pins.out  = cfg.reg_en ? q : result;
   assign pins.cout = carry;

endmodule

//--- design/output_switch_box.sv
`timescale 1ns/1ns

module output_switch_box import fabric_pkg::*, config_pkg::*; (
   input  logic        west,
   input  logic        east,
   input  logic        carry,
   output out_tracks_t out_tracks,
   input  sb_cfg_t     cfg
);
   out_tracks_t drv;

   // 4:1 source mux per output track
   always_comb begin
      for (int t = 0; t < N_OUT_TRACKS; t++) begin
         case (cfg.sel[t])
            SB_WEST:  drv[t] = west;
            SB_EAST:  drv[t] = east;
            SB_CARRY: drv[t] = carry;
            default:  drv[t] = 1'b0;   // unused track held low
         endcase
      end
   end

   assign out_tracks = drv;

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --top-module tile_tb -f compile.f > "$LOG" 2>&1 \
   && ./obj_dir/Vtile_tb >> "$LOG" 2>&1 \
   || echo "build or simulation returned an error" >> "$LOG"

cat "$LOG"
grep -q "Simulation failed" "$LOG" && exit 1
grep -q "Simulation completed successfully" "$LOG" || exit 1
exit 0

//--- testbench/tile_assertions.sv
`timescale 1ns/1ns

module tile_assertions import fabric_pkg::*; (
   input logic        clk,
   input logic        reset,
   input logic        cfg_shift,
   input logic        cfg_out,
   input out_tracks_t out_tracks
);

   // chain comes out of reset empty
   cfg_out_cleared: assert property (@(posedge clk) reset |=> cfg_out == 1'b0)
      else $error("cfg_out not zero in the cycle after reset");

   // no strobe, no movement on the chain
   cfg_out_held: assert property (@(posedge clk) disable iff (reset)
      !cfg_shift |=> $stable(cfg_out))
      else $error("cfg_out changed while cfg_shift was low");

   tracks_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(out_tracks))
      else $error("out_tracks has unknown bits");

endmodule

bind fabric_tile tile_assertions tile_checks (
   .clk(clk),
   .reset(reset),
   .cfg_shift(cfg_shift),
   .cfg_out(cfg_out),
   .out_tracks(out_tracks)
);

//--- testbench/tile_tb.sv
`timescale 1ns/1ns

module tile_tb import fabric_pkg::*, config_pkg::*; ();

   localparam int TIMEOUT_CYCLES = 8 * 2 * CFG_BITS + 900;   // eight loads plus margin

   logic        clk;
   logic        reset;
   logic        cfg_shift;
   logic        cfg_bit;
   logic        carry_in;
   in_tracks_t  in_tracks;
   logic        cfg_out;
   logic        carry_out;
   out_tracks_t out_tracks;

   int cycles       = 0;
   int errors       = 0;
   int test_errors  = 0;
   int tests_run    = 0;
   int tests_failed = 0;

   fabric_tile DUT (
      .clk(clk), .reset(reset), .cfg_shift(cfg_shift), .cfg_bit(cfg_bit),
      .carry_in(carry_in), .in_tracks(in_tracks), .cfg_out(cfg_out),
      .carry_out(carry_out), .out_tracks(out_tracks)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: tests still running after %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic report_mismatch(input string test, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      $display("** Error %s: expected %0h, actual %0h", test, exp_val, act_val);
      test_errors++;
   endtask

   task automatic finish_test(input string test);
      tests_run++;
      if (test_errors == 0) begin
         $display("%s: ok", test);
      end else begin
         $display("%s: %0d mismatches", test, test_errors);
         tests_failed++;
         errors += test_errors;
      end
      test_errors = 0;
   endtask

   // one chain strobe, two cycles
   task automatic shift_bit(input logic b);
      @(posedge clk);
      cfg_shift <= 1'b1;
      cfg_bit   <= b;
      @(posedge clk);
      cfg_shift <= 1'b0;
   endtask

   // MSB first, so the first bit ends at the top of sb
   task automatic load_config(input logic [CFG_BITS-1:0] vec);
      for (int i = CFG_BITS - 1; i >= 0; i--) begin
         shift_bit(vec[i]);
      end
   endtask

   function automatic logic lut_expect(input logic [LUT_SIZE-1:0] truth, input cb_cfg_t cb,
                                       input in_tracks_t tr);
      lut_in_t idx;
      for (int p = 0; p < LUT_K; p++) begin
         idx[p] = tr[cb.sel[p]];
      end
      return truth[idx];
   endfunction

   // switch box codes 1, 2, 1, 2 on tracks 0 to 3
   function automatic out_tracks_t tracks_expect(input logic [LUT_SIZE-1:0] truth_w,
                                                 input logic [LUT_SIZE-1:0] truth_e,
                                                 input cb_cfg_t cb_w, input cb_cfg_t cb_e,
                                                 input in_tracks_t tr);
      logic w;
      logic e;
      w = lut_expect(truth_w, cb_w, tr);
      e = lut_expect(truth_e, cb_e, tr);
      return {e, w, e, w};
   endfunction

   task automatic random_lut_setup(input logic reg_en,
                                   output logic [LUT_SIZE-1:0] truth_w,
                                   output logic [LUT_SIZE-1:0] truth_e,
                                   output cb_cfg_t cb_w, output cb_cfg_t cb_e);
      logic [31:0] r;
      clb_cfg_t    clb_w;
      clb_cfg_t    clb_e;
      sb_cfg_t     sb;
      r       = $urandom;
      truth_w = r[15:0];
      truth_e = r[31:16];
      r       = $urandom;
      cb_w    = r[11:0];
      cb_e    = r[23:12];
      clb_w   = {truth_w, reg_en, 1'b0};   // no carry
      clb_e   = {truth_e, reg_en, 1'b0};
      sb.sel[0] = SB_WEST;
      sb.sel[1] = SB_EAST;
      sb.sel[2] = SB_WEST;
      sb.sel[3] = SB_EAST;
      load_config({sb, clb_e, cb_e, clb_w, cb_w});
   endtask

   task automatic test_reset_state();
      @(negedge clk);
      if (cfg_out !== 1'b0) begin
         report_mismatch("reset_state cfg_out", 32'(1'b0), 32'(cfg_out));
      end
      if (out_tracks !== '0) begin
         report_mismatch("reset_state out_tracks", 32'(0), 32'(out_tracks));
      end
      if (carry_out !== 1'b0) begin
         report_mismatch("reset_state carry_out", 32'(1'b0), 32'(carry_out));
      end
      finish_test("reset_state");
   endtask

   task automatic test_chain_readback();
      logic [CFG_BITS-1:0] bits;
      logic [31:0]         r;
      for (int i = 0; i < CFG_BITS; i++) begin
         r       = $urandom;
         bits[i] = r[0];
         shift_bit(bits[i]);
      end
      // zeros push the random bits out in order
      for (int i = 0; i < CFG_BITS; i++) begin
         @(negedge clk);
         if (cfg_out !== bits[i]) begin
            report_mismatch($sformatf("chain_readback bit %0d", i), 32'(bits[i]), 32'(cfg_out));
         end
         shift_bit(1'b0);
      end
      finish_test("chain_readback");
   endtask

   task automatic test_comb_lut();
      logic [LUT_SIZE-1:0] truth_w;
      logic [LUT_SIZE-1:0] truth_e;
      cb_cfg_t             cb_w;
      cb_cfg_t             cb_e;
      logic [31:0]         r;
      out_tracks_t         exp_tracks;
      random_lut_setup(1'b0, truth_w, truth_e, cb_w, cb_e);
      repeat (16) begin
         r = $urandom;
         @(posedge clk);
         in_tracks <= r[7:0];
         @(negedge clk);   // same cycle
         exp_tracks = tracks_expect(truth_w, truth_e, cb_w, cb_e, r[7:0]);
         if (out_tracks !== exp_tracks) begin
            report_mismatch("comb_lut", 32'(exp_tracks), 32'(out_tracks));
         end
      end
      finish_test("comb_lut");
   endtask

   task automatic test_registered();
      logic [LUT_SIZE-1:0] truth_w;
      logic [LUT_SIZE-1:0] truth_e;
      cb_cfg_t             cb_w;
      cb_cfg_t             cb_e;
      logic [31:0]         r;
      out_tracks_t         old_tracks;
      out_tracks_t         new_tracks;
      random_lut_setup(1'b1, truth_w, truth_e, cb_w, cb_e);
      repeat (16) begin
         r          = $urandom;
         old_tracks = tracks_expect(truth_w, truth_e, cb_w, cb_e, in_tracks);
         new_tracks = tracks_expect(truth_w, truth_e, cb_w, cb_e, r[7:0]);
         @(posedge clk);
         in_tracks <= r[7:0];
         @(negedge clk);
         if (out_tracks !== old_tracks) begin
            report_mismatch("registered hold", 32'(old_tracks), 32'(out_tracks));
         end
         @(posedge clk);   // flop takes the new result here
         @(negedge clk);
         if (out_tracks !== new_tracks) begin
            report_mismatch("registered update", 32'(new_tracks), 32'(out_tracks));
         end
      end
      finish_test("registered");
   endtask

   task automatic test_carry_adder();
      cb_cfg_t     cb_w;
      cb_cfg_t     cb_e;
      clb_cfg_t    clb;
      sb_cfg_t     sb;
      logic [31:0] r;
      logic [1:0]  a;
      logic [1:0]  b;
      logic        c;
      logic [2:0]  sum;
      // tracks 0,1 hold a, tracks 2,3 hold b
      cb_w        = '0;
      cb_w.sel[0] = 3'd0;
      cb_w.sel[1] = 3'd2;
      cb_e        = '0;
      cb_e.sel[0] = 3'd1;
      cb_e.sel[1] = 3'd3;
      for (int i = 0; i < LUT_SIZE; i++) begin
         clb.truth[i] = i[0] ^ i[1];   // pin0 xor pin1
      end
      clb.reg_en     = 1'b0;
      clb.carry_mode = 1'b1;
      sb.sel[0] = SB_WEST;
      sb.sel[1] = SB_EAST;
      sb.sel[2] = SB_CARRY;
      sb.sel[3] = SB_ZERO;
      load_config({sb, clb, cb_e, clb, cb_w});
      for (int v = 0; v < 32; v++) begin
         r   = $urandom;
         a   = v[1:0];
         b   = v[3:2];
         c   = v[4];
         sum = {1'b0, a} + {1'b0, b} + {2'b00, c};
         @(posedge clk);
         in_tracks <= {r[3:0], b, a};   // upper tracks are noise
         carry_in  <= c;
         @(negedge clk);
         if (out_tracks !== {1'b0, sum}) begin
            report_mismatch("carry_adder sum", 32'({1'b0, sum}), 32'(out_tracks));
         end
         if (carry_out !== sum[2]) begin
            report_mismatch("carry_adder carry_out", 32'(sum[2]), 32'(carry_out));
         end
      end
      finish_test("carry_adder");
   endtask

   initial begin
      void'($urandom(32'h28f71063));
      reset     = 1'b1;
      cfg_shift = 1'b0;
      cfg_bit   = 1'b0;
      carry_in  = 1'b0;
      in_tracks = '0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;

      test_reset_state();
      test_chain_readback();
      test_comb_lut();
      test_registered();
      test_carry_adder();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
